//--- vdec_pkg.sv
/*
  shared widths, types and OPV encodings for the two-lane vector decode stage
  imported by every RTL module of the stage
*/
package vdec_pkg;

  // data and element geometry
  localparam int WORD_W    = 32;
  localparam int OFFSET_W  = 8;
  localparam int REG_IDX_W = 5;
  localparam int LANES     = 2;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [OFFSET_W-1:0]  offset_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // execute operation, slides and gather pass operand b through
  typedef enum logic [1:0] {
    ALU_ADD  = 2'd0,
    ALU_SUB  = 2'd1,
    ALU_PASS = 2'd2
  } aluop_t;

  // where the vs2 element offsets come from
  typedef enum logic [1:0] {
    VS2_NORMAL      = 2'd0,
    VS2_IDX_MINUS_1 = 2'd1,
    VS2_IDX_PLUS_1  = 2'd2,
    VS2_RS1         = 2'd3
  } vs2_src_t;

  // operand a selection
  typedef enum logic [1:0] {
    OPA_VS1 = 2'd0,
    OPA_XS1 = 2'd1,
    OPA_IMM = 2'd2
  } opa_src_t;

  // major opcode
  localparam logic [6:0] OPC_OPV = 7'b1010111;

  // funct3 categories
  localparam logic [2:0] F3_OPIVV = 3'b000;
  localparam logic [2:0] F3_OPIVI = 3'b011;
  localparam logic [2:0] F3_OPIVX = 3'b100;
  localparam logic [2:0] F3_OPMVX = 3'b110;

  // funct6 values of the supported subset
  localparam logic [5:0] F6_VADD        = 6'b000000;
  localparam logic [5:0] F6_VSUB        = 6'b000010;
  localparam logic [5:0] F6_VRGATHER    = 6'b001100;
  localparam logic [5:0] F6_VSLIDE1UP   = 6'b001110;
  localparam logic [5:0] F6_VSLIDE1DOWN = 6'b001111;

endpackage

//--- vector_control_unit.sv
/*
  combinational decode of an OPV instruction word into control fields
  de_en is high only for the supported vadd, vsub, slide1 and gather forms
*/
`timescale 1ns/10ps

module vector_control_unit (
  input  vdec_pkg::word_t    instr,
  output logic               de_en,
  output vdec_pkg::aluop_t   aluop,
  output vdec_pkg::opa_src_t opa_src,
  output vdec_pkg::vs2_src_t vs2_src,
  output logic               masked,
  output vdec_pkg::reg_idx_t vs1,
  output vdec_pkg::reg_idx_t vs2,
  output vdec_pkg::reg_idx_t vd,
  output vdec_pkg::word_t    imm
);
  import vdec_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [5:0] funct6;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct6 = instr[31:26];

  // register fields, rs1 and imm5 share the vs1 slot
  assign vs1    = instr[19:15];
  assign vs2    = instr[24:20];
  assign vd     = instr[11:7];
  assign masked = ~instr[25];
  assign imm    = {{(WORD_W-5){instr[19]}}, instr[19:15]};

  always_comb begin
    de_en   = 1'b0;
    aluop   = ALU_PASS;
    opa_src = OPA_VS1;
    vs2_src = VS2_NORMAL;
    if (opcode == OPC_OPV) begin
      case (funct3)
        F3_OPIVV: begin
          opa_src = OPA_VS1;
          de_en   = (funct6 == F6_VADD) || (funct6 == F6_VSUB);
          aluop   = (funct6 == F6_VSUB) ? ALU_SUB : ALU_ADD;
        end
        F3_OPIVX: begin
          opa_src = OPA_XS1;
          if (funct6 == F6_VRGATHER) begin
            // every lane reads element xs1 of vs2
            de_en   = 1'b1;
            vs2_src = VS2_RS1;
          end else begin
            de_en = (funct6 == F6_VADD) || (funct6 == F6_VSUB);
            aluop = (funct6 == F6_VSUB) ? ALU_SUB : ALU_ADD;
          end
        end
        F3_OPIVI: begin
          opa_src = OPA_IMM;
          de_en   = (funct6 == F6_VADD);
          aluop   = ALU_ADD;
        end
        F3_OPMVX: begin
          opa_src = OPA_XS1;
          if (funct6 == F6_VSLIDE1UP) begin
            de_en   = 1'b1;
            vs2_src = VS2_IDX_MINUS_1;
          end else if (funct6 == F6_VSLIDE1DOWN) begin
            de_en   = 1'b1;
            vs2_src = VS2_IDX_PLUS_1;
          end
        end
        default: begin
          de_en = 1'b0;
        end
      endcase
    end
  end

endmodule

//--- element_counter.sv
/*
  walks the element offsets of one instruction, two per cycle from vstart
  reports which lanes are below vl and flags the final beat
*/
`timescale 1ns/10ps

module element_counter (
  input  logic                            CLK,
  input  logic                            nRST,
  input  logic                            de_en,
  input  logic                            stall,
  input  logic                            flush,
  input  vdec_pkg::offset_t               vstart,
  input  vdec_pkg::offset_t               vl,
  output vdec_pkg::offset_t               offset,
  output logic [vdec_pkg::LANES-1:0]      lane_active,
  output logic                            done,
  output logic                            busy
);
  import vdec_pkg::*;

  offset_t               count;
  // one extra bit so the tail compares never wrap
  logic [OFFSET_W:0]     pair_end;

  assign offset   = vstart + count;
  assign pair_end = {1'b0, offset} + (OFFSET_W + 1)'(LANES);

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane_active[i] = ({1'b0, offset} + (OFFSET_W + 1)'(i)) < {1'b0, vl};
    end
  end

  // also covers vl at or below vstart with a single empty beat
  assign done = de_en & (pair_end >= {1'b0, vl});
  assign busy = de_en & ~done;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= '0;
    end else if (flush) begin
      count <= '0;
    end else if (de_en && !stall) begin
      if (done) begin
        count <= '0;
      end else begin
        count <= count + OFFSET_W'(LANES);
      end
    end
  end

endmodule

//--- offset_gen.sv
/*
  per-lane register-file read offsets and destination offsets
  also flags the slide1 boundary lanes that take xs1 instead of vs2
*/
`timescale 1ns/10ps

module offset_gen (
  input  vdec_pkg::offset_t                      offset,
  input  vdec_pkg::vs2_src_t                     vs2_src,
  input  vdec_pkg::word_t                        xs1,
  input  vdec_pkg::offset_t                      vstart,
  input  vdec_pkg::offset_t                      vl,
  output vdec_pkg::offset_t [vdec_pkg::LANES-1:0] vs1_offset,
  output vdec_pkg::offset_t [vdec_pkg::LANES-1:0] vs2_offset,
  output vdec_pkg::offset_t [vdec_pkg::LANES-1:0] woffset,
  output logic [vdec_pkg::LANES-1:0]             xs1_sub
);
  import vdec_pkg::*;

  offset_t [LANES-1:0] lane_offset;

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane_offset[i] = offset + OFFSET_W'(i);
      vs1_offset[i]  = lane_offset[i];
      woffset[i]     = lane_offset[i];

      case (vs2_src)
        VS2_IDX_MINUS_1: vs2_offset[i] = lane_offset[i] - 8'd1;
        VS2_IDX_PLUS_1:  vs2_offset[i] = lane_offset[i] + 8'd1;
        // gather index, upper xs1 bits dropped
        VS2_RS1:         vs2_offset[i] = xs1[OFFSET_W-1:0];
        default:         vs2_offset[i] = lane_offset[i];
      endcase

      // slide1down: the lane that would read element vl
      xs1_sub[i] = (vs2_src == VS2_IDX_PLUS_1) && (vs2_offset[i] == vl);
    end

    // slide1up: first element of the instruction takes xs1
    if ((vs2_src == VS2_IDX_MINUS_1) && (offset == vstart)) begin
      xs1_sub[0] = 1'b1;
    end
  end

endmodule

//--- decode_execute_reg.sv
/*
  operand selection, masked write enables and the decode-to-execute register
  flush clears the beat and wins over stall, stall holds it
*/
`timescale 1ns/10ps

module decode_execute_reg (
  input  logic                                    CLK,
  input  logic                                    nRST,
  input  logic                                    stall,
  input  logic                                    flush,
  input  logic                                    de_en,
  input  vdec_pkg::aluop_t                        aluop,
  input  vdec_pkg::opa_src_t                      opa_src,
  input  logic                                    masked,
  input  vdec_pkg::reg_idx_t                      vd,
  input  vdec_pkg::word_t                         imm,
  input  vdec_pkg::word_t                         xs1,
  input  vdec_pkg::word_t [vdec_pkg::LANES-1:0]   vs1_data,
  input  vdec_pkg::word_t [vdec_pkg::LANES-1:0]   vs2_data,
  input  logic [vdec_pkg::LANES-1:0]              v0_mask,
  input  logic [vdec_pkg::LANES-1:0]              lane_active,
  input  logic [vdec_pkg::LANES-1:0]              xs1_sub,
  input  vdec_pkg::offset_t [vdec_pkg::LANES-1:0] woffset,
  input  logic                                    done,
  output vdec_pkg::aluop_t                        ex_aluop,
  output vdec_pkg::reg_idx_t                      ex_vd,
  output vdec_pkg::offset_t [vdec_pkg::LANES-1:0] ex_woffset,
  output vdec_pkg::word_t [vdec_pkg::LANES-1:0]   ex_opa,
  output vdec_pkg::word_t [vdec_pkg::LANES-1:0]   ex_opb,
  output logic [vdec_pkg::LANES-1:0]              ex_wen,
  output logic                                    ex_decode_done
);
  import vdec_pkg::*;

  word_t [LANES-1:0]  opa;
  word_t [LANES-1:0]  opb;
  logic [LANES-1:0]   wen;

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      case (opa_src)
        OPA_XS1: opa[i] = xs1;
        OPA_IMM: opa[i] = imm;
        default: opa[i] = vs1_data[i];
      endcase
      // slide boundary lanes take the scalar
      opb[i] = xs1_sub[i] ? xs1 : vs2_data[i];
      // v0 only matters for masked forms
      wen[i] = de_en & lane_active[i] & (~masked | v0_mask[i]);
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_aluop       <= ALU_ADD;
      ex_vd          <= '0;
      ex_woffset     <= '0;
      ex_opa         <= '0;
      ex_opb         <= '0;
      ex_wen         <= '0;
      ex_decode_done <= 1'b0;
    end else if (flush) begin
      ex_aluop       <= ALU_ADD;
      ex_vd          <= '0;
      ex_woffset     <= '0;
      ex_opa         <= '0;
      ex_opb         <= '0;
      ex_wen         <= '0;
      ex_decode_done <= 1'b0;
    end else if (!stall) begin
      ex_aluop       <= aluop;
      ex_vd          <= vd;
      ex_woffset     <= woffset;
      ex_opa         <= opa;
      ex_opb         <= opb;
      ex_wen         <= wen;
      ex_decode_done <= done;
    end
  end

endmodule

//--- rv32v_decode_stage.sv
/*
  two-lane vector decode stage top, reads the register file through its ports
  and hands one registered beat per cycle to execute
*/
`timescale 1ns/10ps

module rv32v_decode_stage (
  input  logic                                    CLK,
  input  logic                                    nRST,
  input  vdec_pkg::word_t                         instr,
  input  vdec_pkg::word_t                         xs1,
  input  vdec_pkg::offset_t                       vstart,
  input  vdec_pkg::offset_t                       vl,
  input  logic                                    stall,
  input  logic                                    flush,
  input  vdec_pkg::word_t [vdec_pkg::LANES-1:0]   vs1_data,
  input  vdec_pkg::word_t [vdec_pkg::LANES-1:0]   vs2_data,
  input  logic [vdec_pkg::LANES-1:0]              v0_mask,
  output logic                                    busy,
  output vdec_pkg::reg_idx_t                      vs1_idx,
  output vdec_pkg::reg_idx_t                      vs2_idx,
  output vdec_pkg::offset_t [vdec_pkg::LANES-1:0] vs1_offset,
  output vdec_pkg::offset_t [vdec_pkg::LANES-1:0] vs2_offset,
  output vdec_pkg::aluop_t                        ex_aluop,
  output vdec_pkg::reg_idx_t                      ex_vd,
  output vdec_pkg::offset_t [vdec_pkg::LANES-1:0] ex_woffset,
  output vdec_pkg::word_t [vdec_pkg::LANES-1:0]   ex_opa,
  output vdec_pkg::word_t [vdec_pkg::LANES-1:0]   ex_opb,
  output logic [vdec_pkg::LANES-1:0]              ex_wen,
  output logic                                    ex_decode_done
);
  import vdec_pkg::*;

  // decode fields
  logic                de_en;
  aluop_t              aluop;
  opa_src_t            opa_src;
  vs2_src_t            vs2_src;
  logic                masked;
  reg_idx_t            vd;
  word_t               imm;

  // sequencing and offsets
  offset_t             offset;
  logic [LANES-1:0]    lane_active;
  logic                done;
  offset_t [LANES-1:0] woffset;
  logic [LANES-1:0]    xs1_sub;

  vector_control_unit i_vector_control_unit (
    .instr   (instr),
    .de_en   (de_en),
    .aluop   (aluop),
    .opa_src (opa_src),
    .vs2_src (vs2_src),
    .masked  (masked),
    .vs1     (vs1_idx),
    .vs2     (vs2_idx),
    .vd      (vd),
    .imm     (imm)
  );

  element_counter i_element_counter (
    .CLK         (CLK),
    .nRST        (nRST),
    .de_en       (de_en),
    .stall       (stall),
    .flush       (flush),
    .vstart      (vstart),
    .vl          (vl),
    .offset      (offset),
    .lane_active (lane_active),
    .done        (done),
    .busy        (busy)
  );

  offset_gen i_offset_gen (
    .offset     (offset),
    .vs2_src    (vs2_src),
    .xs1        (xs1),
    .vstart     (vstart),
    .vl         (vl),
    .vs1_offset (vs1_offset),
    .vs2_offset (vs2_offset),
    .woffset    (woffset),
    .xs1_sub    (xs1_sub)
  );

  decode_execute_reg i_decode_execute_reg (
    .CLK            (CLK),
    .nRST           (nRST),
    .stall          (stall),
    .flush          (flush),
    .de_en          (de_en),
    .aluop          (aluop),
    .opa_src        (opa_src),
    .masked         (masked),
    .vd             (vd),
    .imm            (imm),
    .xs1            (xs1),
    .vs1_data       (vs1_data),
    .vs2_data       (vs2_data),
    .v0_mask        (v0_mask),
    .lane_active    (lane_active),
    .xs1_sub        (xs1_sub),
    .woffset        (woffset),
    .done           (done),
    .ex_aluop       (ex_aluop),
    .ex_vd          (ex_vd),
    .ex_woffset     (ex_woffset),
    .ex_opa         (ex_opa),
    .ex_opb         (ex_opb),
    .ex_wen         (ex_wen),
    .ex_decode_done (ex_decode_done)
  );

endmodule

//--- tb_decode_stage.sv
/*
  directed testbench for the two-lane vector decode stage
  models the register file and v0 combinationally and checks every ex_ beat
*/
`timescale 1ns/10ps

module tb_decode_stage;
  import vdec_pkg::*;

  logic                CLK = 1'b0;
  logic                nRST;
  word_t               instr, xs1;
  offset_t             vstart, vl;
  logic                stall, flush;
  word_t [LANES-1:0]   vs1_data, vs2_data;
  logic [LANES-1:0]    v0_mask;
  logic                busy;
  reg_idx_t            vs1_idx, vs2_idx, ex_vd;
  offset_t [LANES-1:0] vs1_offset, vs2_offset, ex_woffset;
  aluop_t              ex_aluop;
  word_t [LANES-1:0]   ex_opa, ex_opb;
  logic [LANES-1:0]    ex_wen;
  logic                ex_decode_done;

  // v0 contents and the instruction in flight
  logic [31:0]         mask_word;
  reg_idx_t            e_v1, e_v2, e_vd;
  aluop_t              e_alu;
  int                  e_opa, e_opb;
  logic                e_vm;

  rv32v_decode_stage i_rv32v_decode_stage (.*);

  always #20 CLK = ~CLK;

  // register r at offset o holds r*256+o, the element offset equals vs1_offset
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      vs1_data[i] = 32'(vs1_idx) * 256 + 32'(vs1_offset[i]);
      vs2_data[i] = 32'(vs2_idx) * 256 + 32'(vs2_offset[i]);
      v0_mask[i]  = mask_word[vs1_offset[i][4:0]];
    end
  end

  // several times the length of all tests
  initial begin
    repeat (400) @(posedge CLK);
    $display("CHECKS FAILED");
    $fatal(1, "timeout, the tests did not finish within 400 clock cycles");
  end

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s: got %0h, expected %0h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  function automatic int beat_count(input int vs, input int l);
    return (l > vs) ? (l - vs + 1) / 2 : 1;
  endfunction

  // expected beat b of nb, derived from the current inputs
  task automatic check_beat(input int b, input int nb);
    int          o;
    logic [31:0] opa_exp, opb_exp, base;
    for (int i = 0; i < LANES; i++) begin
      o    = (int'(vstart) + 2 * b + i) % 256;
      base = 32'(e_v2) * 256;
      case (e_opa)
        1:       opa_exp = xs1;
        2:       opa_exp = {{27{e_v1[4]}}, e_v1};
        default: opa_exp = 32'(e_v1) * 256 + 32'(o);
      endcase
      case (e_opb)
        1:       opb_exp = (i == 0 && o == int'(vstart)) ? xs1 : base + 32'((o + 255) % 256);
        2:       opb_exp = ((o + 1) % 256 == int'(vl)) ? xs1 : base + 32'((o + 1) % 256);
        3:       opb_exp = base + 32'(xs1[7:0]);
        default: opb_exp = base + 32'(o);
      endcase
      check($sformatf("lane %0d woffset", i), 32'(ex_woffset[i]), 32'(o));
      check($sformatf("lane %0d wen", i), 32'(ex_wen[i]),
            32'((o < int'(vl)) && (e_vm || mask_word[5'(o % 32)])));
      check($sformatf("lane %0d opa", i), ex_opa[i], opa_exp);
      check($sformatf("lane %0d opb", i), ex_opb[i], opb_exp);
    end
    check("aluop", 32'(ex_aluop), 32'(e_alu));
    check("vd", 32'(ex_vd), 32'(e_vd));
    check("decode_done", 32'(ex_decode_done), 32'(b == nb - 1));
  endtask

  task automatic load_instr(input logic [5:0] f6, input logic [2:0] f3, input logic vm,
                            input aluop_t alu, input int opa_kind, input int opb_kind,
                            input int vs, input int l, input word_t x, input logic [31:0] m);
    e_alu = alu;
    e_opa = opa_kind;
    e_opb = opb_kind;
    e_vm  = vm;
    @(posedge CLK);
    instr     <= {f6, vm, e_v2, e_v1, f3, e_vd, OPC_OPV};
    vstart    <= offset_t'(vs);
    vl        <= offset_t'(l);
    xs1       <= x;
    mask_word <= m;
  endtask

  // called at a falling edge, the instruction is removed with its last beat
  task automatic step_beats(input int nb);
    for (int b = 0; b < nb; b++) begin
      check("busy", 32'(busy), 32'(b != nb - 1));
      @(posedge CLK);
      if (b == nb - 1) begin
        instr <= '0;
      end
      @(negedge CLK);
      check_beat(b, nb);
    end
  endtask

  task automatic run_instr(input logic [5:0] f6, input logic [2:0] f3, input logic vm,
                           input aluop_t alu, input int opa_kind, input int opb_kind,
                           input int vs, input int l, input word_t x, input logic [31:0] m);
    load_instr(f6, f3, vm, alu, opa_kind, opb_kind, vs, l, x, m);
    @(negedge CLK);
    step_beats(beat_count(vs, l));
  endtask

  task automatic test_reset();
    @(negedge CLK);
    check("busy after reset", 32'(busy), 32'd0);
    check("wen after reset", 32'(ex_wen), 32'd0);
    check("decode_done after reset", 32'(ex_decode_done), 32'd0);
  endtask

  task automatic test_arith();
    word_t x;
    x = $urandom();
    // unmasked forms ignore a random v0
    run_instr(F6_VADD, F3_OPIVV, 1'b1, ALU_ADD, 0, 0, 0, 5, x, $urandom());
    run_instr(F6_VADD, F3_OPIVX, 1'b1, ALU_ADD, 1, 0, 0, 5, x, $urandom());
    run_instr(F6_VADD, F3_OPIVI, 1'b1, ALU_ADD, 2, 0, 0, 5, x, $urandom());
    // masked subtract against a random v0
    run_instr(F6_VSUB, F3_OPIVV, 1'b0, ALU_SUB, 0, 0, 0, 8, x, $urandom());
  endtask

  task automatic test_permute();
    run_instr(F6_VSLIDE1UP, F3_OPMVX, 1'b1, ALU_PASS, 1, 1, 1, 6, $urandom(), '1);
    run_instr(F6_VSLIDE1DOWN, F3_OPMVX, 1'b1, ALU_PASS, 1, 2, 0, 5, $urandom(), '1);
    run_instr(F6_VSLIDE1DOWN, F3_OPMVX, 1'b1, ALU_PASS, 1, 2, 0, 6, $urandom(), '1);
    run_instr(F6_VRGATHER, F3_OPIVX, 1'b1, ALU_PASS, 1, 3, 0, 4, $urandom(), '1);
  endtask

  task automatic test_stall_flush();
    load_instr(F6_VADD, F3_OPIVV, 1'b1, ALU_ADD, 0, 0, 2, 9, '0, '1);
    @(posedge CLK);
    @(negedge CLK);
    check_beat(0, 4);
    @(posedge CLK);
    stall <= 1'b1;
    @(negedge CLK);
    check_beat(1, 4);
    repeat (3) begin
      @(posedge CLK);
      @(negedge CLK);
      check_beat(1, 4);
      check("busy in stall", 32'(busy), 32'd1);
    end
    // flush while the stall is still up
    @(posedge CLK);
    flush <= 1'b1;
    @(posedge CLK);
    flush <= 1'b0;
    stall <= 1'b0;
    @(negedge CLK);
    check("wen after flush", 32'(ex_wen), 32'd0);
    step_beats(4);
    // a final beat held by stall is still dropped by flush
    load_instr(F6_VADD, F3_OPIVV, 1'b1, ALU_ADD, 0, 0, 0, 2, '0, '1);
    @(posedge CLK);
    instr <= '0;
    stall <= 1'b1;
    @(negedge CLK);
    check_beat(0, 1);
    @(posedge CLK);
    flush <= 1'b1;
    @(posedge CLK);
    flush <= 1'b0;
    stall <= 1'b0;
    @(negedge CLK);
    check("wen after flush", 32'(ex_wen), 32'd0);
    check("decode_done after flush", 32'(ex_decode_done), 32'd0);
  endtask

  task automatic test_illegal();
    @(posedge CLK);
    instr <= {F6_VSUB, 1'b1, e_v2, e_v1, F3_OPIVI, e_vd, OPC_OPV};
    repeat (2) begin
      @(negedge CLK);
      check("busy on illegal word", 32'(busy), 32'd0);
      check("wen on illegal word", 32'(ex_wen), 32'd0);
    end
    @(posedge CLK);
    instr <= {6'b111111, 1'b1, e_v2, e_v1, F3_OPIVV, e_vd, OPC_OPV};
    repeat (2) begin
      @(negedge CLK);
      check("busy on illegal word", 32'(busy), 32'd0);
      check("wen on illegal word", 32'(ex_wen), 32'd0);
    end
  endtask

  initial begin
    void'($urandom(32'hd7e16d92));
    nRST      = 1'b0;
    instr     = '0;
    xs1       = '0;
    vstart    = '0;
    vl        = '0;
    stall     = 1'b0;
    flush     = 1'b0;
    mask_word = '0;
    e_v1      = 5'd22;
    e_v2      = 5'd3;
    e_vd      = 5'd7;
    repeat (10) @(posedge CLK);
    nRST <= 1'b1;
    test_reset();
    test_arith();
    test_permute();
    test_stall_flush();
    test_illegal();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- sources.f
vdec_pkg.sv
vector_control_unit.sv
element_counter.sv
offset_gen.sv
decode_execute_reg.sv
rv32v_decode_stage.sv
tb_decode_stage.sv

//--- run.sh
#!/usr/bin/env bash
# build the decode stage testbench with Verilator and run it
cd "$(dirname "$0")" && \
  verilator --binary -f sources.f --top-module tb_decode_stage -o tb_decode_stage && \
  ./obj_dir/tb_decode_stage || { echo "simulation failed"; exit 1; }
